/* source/ex_isa_pkg.sv */
`default_nettype none

package ex_isa_pkg;

    // integer register width, rv64
    localparam int xlen = 64;

    // fixed instruction size, no compressed support
    localparam int inst_bytes = 4;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [xlen-1:0] word_t;

    // decoded execute operation
    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_sll,
        op_slt,
        op_sltu,
        op_xor,
        op_srl,
        op_sra,
        op_or,
        op_and,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_mul,
        op_load,
        op_store
    } ex_op_e;

endpackage

`default_nettype wire

/* source/ex_pipe_pkg.sv */
`default_nettype none

package ex_pipe_pkg;

    // decode to execute
    typedef struct packed {
        ex_isa_pkg::word_t    pc;
        ex_isa_pkg::ex_op_e   op;
        logic                 use_imm;
        ex_isa_pkg::reg_idx_t rd;
        ex_isa_pkg::reg_idx_t rs1;
        ex_isa_pkg::reg_idx_t rs2;
        ex_isa_pkg::word_t    src_a;
        ex_isa_pkg::word_t    src_b;
        ex_isa_pkg::word_t    imm;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        ex_isa_pkg::word_t    pc;
        ex_isa_pkg::ex_op_e   op;
        ex_isa_pkg::reg_idx_t rd;
        ex_isa_pkg::word_t    result;
        ex_isa_pkg::word_t    store_data;
    } ex_mem_t;

    // one forwarding source, mem or wb
    typedef struct packed {
        logic                 wen;
        ex_isa_pkg::reg_idx_t rd;
        ex_isa_pkg::word_t    data;
    } bypass_t;

    // fetch restarts at target when valid
    typedef struct packed {
        logic              valid;
        ex_isa_pkg::word_t target;
    } redirect_t;

endpackage

`default_nettype wire

/* source/ex_stage_reg.sv */
`default_nettype none

module ex_stage_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                in_valid,
    output logic                in_ready,
    input  ex_pipe_pkg::id_ex_t in_item,
    input  logic                mul_stall,
    input  logic                out_ready,
    output ex_pipe_pkg::id_ex_t item,
    output logic                item_valid,
    output logic                out_valid
);

    // stage advances only when mem accepts and no multiply is pending
    assign in_ready  = out_ready && !mul_stall;
    assign out_valid = item_valid && !mul_stall;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            item_valid <= 1'b0;
        end else if (in_ready) begin
            item_valid <= in_valid;
        end
    end

    // payload only, qualified by item_valid
    always_ff @(posedge clk) begin
        if (in_ready) begin
            item <= in_item;
        end
    end

    // a flushed stage must come back empty
    a_flush_empties: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid
    );

endmodule

`default_nettype wire

/* source/ex_bypass.sv */
`default_nettype none

module ex_bypass (
    input  ex_isa_pkg::reg_idx_t rs1,
    input  ex_isa_pkg::reg_idx_t rs2,
    input  ex_isa_pkg::word_t    src_a,
    input  ex_isa_pkg::word_t    src_b,
    input  ex_pipe_pkg::bypass_t mem_fwd,
    input  ex_pipe_pkg::bypass_t wb_fwd,
    output ex_isa_pkg::word_t    opa,
    output ex_isa_pkg::word_t    opb
);

    // mem is younger than wb so it wins, x0 is never forwarded
    function automatic ex_isa_pkg::word_t pick(
        input ex_isa_pkg::reg_idx_t rs,
        input ex_isa_pkg::word_t    reg_val,
        input ex_pipe_pkg::bypass_t mem_src,
        input ex_pipe_pkg::bypass_t wb_src
    );
        logic nonzero;
        nonzero = (rs != '0);
        if (nonzero && mem_src.wen && mem_src.rd == rs) begin
            return mem_src.data;
        end else if (nonzero && wb_src.wen && wb_src.rd == rs) begin
            return wb_src.data;
        end
        return reg_val;
    endfunction

    assign opa = pick(rs1, src_a, mem_fwd, wb_fwd);
    assign opb = pick(rs2, src_b, mem_fwd, wb_fwd);

endmodule

`default_nettype wire

/* source/ex_alu.sv */
`default_nettype none

module ex_alu (
    input  ex_pipe_pkg::id_ex_t item,
    input  ex_isa_pkg::word_t   opa,
    input  ex_isa_pkg::word_t   opb,
    output ex_isa_pkg::word_t   alu_result
);

    ex_isa_pkg::word_t b;
    logic [5:0]        shamt;
    ex_isa_pkg::word_t link_pc;
    ex_isa_pkg::word_t addr_sum;

    // immediate forms replace rs2
    assign b     = item.use_imm ? item.imm : opb;
    assign shamt = b[5:0];

    // return address for jal and jalr
    assign link_pc = item.pc + ex_isa_pkg::word_t'(ex_isa_pkg::inst_bytes);

    // effective address of loads and stores
    assign addr_sum = opa + item.imm;

    always_comb begin
        case (item.op)
            ex_isa_pkg::op_add:   alu_result = opa + b;
            ex_isa_pkg::op_sub:   alu_result = opa - b;
            ex_isa_pkg::op_sll:   alu_result = opa << shamt;
            ex_isa_pkg::op_slt: begin
                alu_result = ex_isa_pkg::word_t'($signed(opa) < $signed(b));
            end
            ex_isa_pkg::op_sltu:  alu_result = ex_isa_pkg::word_t'(opa < b);
            ex_isa_pkg::op_xor:   alu_result = opa ^ b;
            ex_isa_pkg::op_srl:   alu_result = opa >> shamt;
            ex_isa_pkg::op_sra: begin
                alu_result = ex_isa_pkg::word_t'($signed(opa) >>> shamt);
            end
            ex_isa_pkg::op_or:    alu_result = opa | b;
            ex_isa_pkg::op_and:   alu_result = opa & b;
            ex_isa_pkg::op_lui:   alu_result = item.imm;
            ex_isa_pkg::op_auipc: alu_result = item.pc + item.imm;
            ex_isa_pkg::op_jal,
            ex_isa_pkg::op_jalr:  alu_result = link_pc;
            ex_isa_pkg::op_load,
            ex_isa_pkg::op_store: alu_result = addr_sum;
            // branches write no register
            default:              alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/ex_branch.sv */
`default_nettype none

module ex_branch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ex_pipe_pkg::id_ex_t    item,
    input  logic                   item_valid,
    input  ex_isa_pkg::word_t      opa,
    input  ex_isa_pkg::word_t      opb,
    input  logic                   out_ready,
    input  logic                   mul_stall,
    output ex_pipe_pkg::redirect_t redirect
);

    logic              taken;
    logic              is_jump;
    logic              leaving;
    ex_isa_pkg::word_t jalr_sum;

    always_comb begin
        case (item.op)
            ex_isa_pkg::op_beq:  taken = (opa == opb);
            ex_isa_pkg::op_bne:  taken = (opa != opb);
            ex_isa_pkg::op_blt:  taken = ($signed(opa) < $signed(opb));
            ex_isa_pkg::op_bge:  taken = ($signed(opa) >= $signed(opb));
            ex_isa_pkg::op_bltu: taken = (opa < opb);
            ex_isa_pkg::op_bgeu: taken = (opa >= opb);
            default:             taken = 1'b0;
        endcase
    end

    assign is_jump = (item.op == ex_isa_pkg::op_jal) || (item.op == ex_isa_pkg::op_jalr);

    // redirect only on the cycle the item moves on to mem
    assign leaving = item_valid && out_ready && !mul_stall;

    assign jalr_sum = opa + item.imm;

    assign redirect.valid  = leaving && (taken || is_jump);
    assign redirect.target = (item.op == ex_isa_pkg::op_jalr) ?
                             {jalr_sum[ex_isa_pkg::xlen-1:1], 1'b0} :
                             item.pc + item.imm;

    a_redirect_on_transfer: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect.valid |-> out_ready
    );

endmodule

`default_nettype wire

/* source/ex_multiplier.sv */
`default_nettype none

module ex_multiplier #(
    parameter int mul_bits_per_cycle = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  ex_pipe_pkg::id_ex_t item,
    input  logic                item_valid,
    input  logic                out_ready,
    input  ex_isa_pkg::word_t   opa,
    input  ex_isa_pkg::word_t   opb,
    input  ex_isa_pkg::word_t   alu_result,
    output logic                mul_stall,
    output ex_isa_pkg::word_t   result
);

    localparam int steps = ex_isa_pkg::xlen / mul_bits_per_cycle;
    localparam int cnt_w = $clog2(steps);

    typedef enum logic [1:0] {st_idle, st_busy, st_done} mul_state_e;

    mul_state_e        state_q;
    logic              is_mul;
    logic [cnt_w-1:0]  cnt_q;
    ex_isa_pkg::word_t mcand_q;
    ex_isa_pkg::word_t mplier_q;
    ex_isa_pkg::word_t product_q;
    ex_isa_pkg::word_t partial;

    assign is_mul = item_valid && (item.op == ex_isa_pkg::op_mul);

    // sum of the shifted multiplicand for the bits retired this cycle
    always_comb begin
        partial = '0;
        for (int i = 0; i < mul_bits_per_cycle; i++) begin
            if (mplier_q[i]) begin
                partial = partial + (mcand_q << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: if (is_mul) state_q <= st_busy;
                st_busy: if (cnt_q == '0) state_q <= st_done;
                // product is consumed when mem takes the item
                st_done: if (out_ready) state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle) begin
            mcand_q   <= opa;
            mplier_q  <= opb;
            product_q <= '0;
            cnt_q     <= cnt_w'(steps - 1);
        end else if (state_q == st_busy) begin
            mcand_q   <= mcand_q << mul_bits_per_cycle;
            mplier_q  <= mplier_q >> mul_bits_per_cycle;
            product_q <= product_q + partial;
            cnt_q     <= cnt_q - 1'b1;
        end
    end

    assign mul_stall = is_mul && (state_q != st_done);
    assign result    = (item.op == ex_isa_pkg::op_mul) ? product_q : alu_result;

    a_start_on_mul: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == st_idle) ##1 (state_q != st_idle) |->
            $past(is_mul)
    );

endmodule

`default_nettype wire

/* source/ex_stage.sv */
`default_nettype none

module ex_stage #(
    parameter int mul_bits_per_cycle = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  ex_pipe_pkg::id_ex_t    in_item,
    output logic                   out_valid,
    input  logic                   out_ready,
    output ex_pipe_pkg::ex_mem_t   out_item,
    input  ex_pipe_pkg::bypass_t   mem_fwd,
    input  ex_pipe_pkg::bypass_t   wb_fwd,
    input  logic                   flush,
    output ex_pipe_pkg::redirect_t redirect
);

    ex_pipe_pkg::id_ex_t item;
    logic                item_valid;
    logic                mul_stall;
    ex_isa_pkg::word_t   opa;
    ex_isa_pkg::word_t   opb;
    ex_isa_pkg::word_t   alu_result;
    ex_isa_pkg::word_t   result;

    ex_stage_reg i_stage_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_item    (in_item),
        .mul_stall  (mul_stall),
        .out_ready  (out_ready),
        .item       (item),
        .item_valid (item_valid),
        .out_valid  (out_valid)
    );

    ex_bypass i_bypass (
        .rs1     (item.rs1),
        .rs2     (item.rs2),
        .src_a   (item.src_a),
        .src_b   (item.src_b),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .opa     (opa),
        .opb     (opb)
    );

    ex_alu i_alu (
        .item       (item),
        .opa        (opa),
        .opb        (opb),
        .alu_result (alu_result)
    );

    ex_branch i_branch (
        .clk        (clk),
        .rst_n      (rst_n),
        .item       (item),
        .item_valid (item_valid),
        .opa        (opa),
        .opb        (opb),
        .out_ready  (out_ready),
        .mul_stall  (mul_stall),
        .redirect   (redirect)
    );

    ex_multiplier #(
        .mul_bits_per_cycle (mul_bits_per_cycle)
    ) i_multiplier (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .item       (item),
        .item_valid (item_valid),
        .out_ready  (out_ready),
        .opa        (opa),
        .opb        (opb),
        .alu_result (alu_result),
        .mul_stall  (mul_stall),
        .result     (result)
    );

    // forwarded rs2 is the store data
    assign out_item = '{
        pc:         item.pc,
        op:         item.op,
        rd:         item.rd,
        result:     result,
        store_data: opb
    };

endmodule

`default_nettype wire

/* verif/ex_stage_tb.sv */
`default_nettype none

module ex_stage_tb #(
    parameter int mul_bits_per_cycle = 2
);

    localparam int clk_period   = 40;
    localparam int drive_dly    = 2;
    localparam int reset_cycles = 10;
    localparam int mul_steps    = ex_isa_pkg::xlen / mul_bits_per_cycle;
    // alu 28, bypass 4, branch 20, mul 4, back-pressure 1, flush 3
    localparam int num_ops      = 60;
    localparam int cycle_limit  = num_ops * (mul_steps + 4) + reset_cycles;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic                   in_ready;
    ex_pipe_pkg::id_ex_t    in_item;
    logic                   out_valid;
    logic                   out_ready;
    ex_pipe_pkg::ex_mem_t   out_item;
    ex_pipe_pkg::bypass_t   mem_fwd;
    ex_pipe_pkg::bypass_t   wb_fwd;
    logic                   flush;
    ex_pipe_pkg::redirect_t redirect;

    int                cycles;
    logic [31:0]       lfsr_q;
    ex_isa_pkg::word_t next_pc;

    ex_stage #(
        .mul_bits_per_cycle (mul_bits_per_cycle)
    ) i_ex_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_item   (in_item),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_item  (out_item),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .flush     (flush),
        .redirect  (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: DUT gave no response within %0d cycles", cycles);
            stop_run();
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic ex_isa_pkg::word_t rand_word(input int nbits);
        ex_isa_pkg::word_t w;
        logic              fb;
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            w      = {w[ex_isa_pkg::xlen-2:0], fb};
        end
        return w;
    endfunction

    // sign extended 12-bit immediate
    function automatic ex_isa_pkg::word_t rand_imm();
        ex_isa_pkg::word_t r;
        r = rand_word(12);
        return {{(ex_isa_pkg::xlen-12){r[11]}}, r[11:0]};
    endfunction

    function automatic ex_pipe_pkg::id_ex_t make_item(
        input ex_isa_pkg::ex_op_e   op,
        input logic                 use_imm,
        input ex_isa_pkg::reg_idx_t rs1,
        input ex_isa_pkg::reg_idx_t rs2,
        input ex_isa_pkg::word_t    a,
        input ex_isa_pkg::word_t    b,
        input ex_isa_pkg::word_t    imm
    );
        ex_pipe_pkg::id_ex_t it;
        it.pc      = next_pc;
        it.op      = op;
        it.use_imm = use_imm;
        it.rd      = 5'd10;
        it.rs1     = rs1;
        it.rs2     = rs2;
        it.src_a   = a;
        it.src_b   = b;
        it.imm     = imm;
        next_pc    = next_pc + 64'd4;
        return it;
    endfunction

    // expected result from the isa rules where rb is the rs2 value after bypass
    function automatic ex_isa_pkg::word_t ref_result(
        input ex_pipe_pkg::id_ex_t it,
        input ex_isa_pkg::word_t   a,
        input ex_isa_pkg::word_t   rb
    );
        ex_isa_pkg::word_t b;
        logic [5:0]        sh;
        b  = it.use_imm ? it.imm : rb;
        sh = b[5:0];
        case (it.op)
            ex_isa_pkg::op_add:   return a + b;
            ex_isa_pkg::op_sub:   return a - b;
            ex_isa_pkg::op_sll:   return a << sh;
            ex_isa_pkg::op_slt:   return {{(ex_isa_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            ex_isa_pkg::op_sltu:  return {{(ex_isa_pkg::xlen-1){1'b0}}, a < b};
            ex_isa_pkg::op_xor:   return a ^ b;
            ex_isa_pkg::op_srl:   return a >> sh;
            ex_isa_pkg::op_sra:   return ex_isa_pkg::word_t'($signed(a) >>> sh);
            ex_isa_pkg::op_or:    return a | b;
            ex_isa_pkg::op_and:   return a & b;
            ex_isa_pkg::op_lui:   return it.imm;
            ex_isa_pkg::op_auipc: return it.pc + it.imm;
            ex_isa_pkg::op_jal,
            ex_isa_pkg::op_jalr:  return it.pc + 64'd4;
            ex_isa_pkg::op_load,
            ex_isa_pkg::op_store: return a + it.imm;
            ex_isa_pkg::op_mul:   return a * rb;
            default:              return '0;
        endcase
    endfunction

    function automatic ex_pipe_pkg::redirect_t ref_redirect(
        input ex_pipe_pkg::id_ex_t it,
        input ex_isa_pkg::word_t   a,
        input ex_isa_pkg::word_t   b
    );
        ex_pipe_pkg::redirect_t r;
        logic                   taken;
        case (it.op)
            ex_isa_pkg::op_beq:  taken = (a == b);
            ex_isa_pkg::op_bne:  taken = (a != b);
            ex_isa_pkg::op_blt:  taken = ($signed(a) < $signed(b));
            ex_isa_pkg::op_bge:  taken = !($signed(a) < $signed(b));
            ex_isa_pkg::op_bltu: taken = (a < b);
            ex_isa_pkg::op_bgeu: taken = !(a < b);
            default:             taken = 1'b0;
        endcase
        r.valid  = taken || it.op == ex_isa_pkg::op_jal || it.op == ex_isa_pkg::op_jalr;
        r.target = it.pc + it.imm;
        if (it.op == ex_isa_pkg::op_jalr) begin
            r.target = (a + it.imm) & ~ex_isa_pkg::word_t'(1);
        end
        return r;
    endfunction

    function automatic ex_pipe_pkg::ex_mem_t expect_out(
        input ex_pipe_pkg::id_ex_t it,
        input ex_isa_pkg::word_t   a,
        input ex_isa_pkg::word_t   b
    );
        return '{pc: it.pc, op: it.op, rd: it.rd, result: ref_result(it, a, b), store_data: b};
    endfunction

    task automatic check_bit(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", test, exp, act);
            stop_run();
        end
    endtask

    task automatic check_latency(input string test, input int exp, input int act);
        if (act != exp) begin
            $display("** Error %s: expected %0d cycles, actual %0d cycles", test, exp, act);
            stop_run();
        end
    endtask

    task automatic check_ex_mem(input string test, input ex_pipe_pkg::ex_mem_t exp,
                                input ex_pipe_pkg::ex_mem_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", test, exp, act);
            stop_run();
        end
    endtask

    // target only matters when a redirect is issued
    task automatic check_redirect(input string test, input ex_pipe_pkg::redirect_t exp,
                                  input ex_pipe_pkg::redirect_t act);
        if (act.valid !== exp.valid || (exp.valid && act.target !== exp.target)) begin
            $display("** Error %s: expected valid=%b target=%h, actual valid=%b target=%h",
                     test, exp.valid, exp.target, act.valid, act.target);
            stop_run();
        end
    endtask

    // returns one drive delay after the accepting edge
    task automatic accept(input ex_pipe_pkg::id_ex_t it);
        in_item  = it;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #drive_dly;
        in_valid = 1'b0;
    endtask

    task automatic run_single(input string test, input ex_pipe_pkg::id_ex_t it,
                              input ex_isa_pkg::word_t a, input ex_isa_pkg::word_t b);
        accept(it);
        @(negedge clk);
        check_bit(test, 1'b1, out_valid);
        check_ex_mem(test, expect_out(it, a, b), out_item);
        check_redirect(test, ref_redirect(it, a, b), redirect);
        @(posedge clk);
        #drive_dly;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_bit("reset out_valid", 1'b0, out_valid);
        check_bit("reset redirect", 1'b0, redirect.valid);
        check_bit("reset in_ready", 1'b1, in_ready);
        @(posedge clk);
        #drive_dly;
    endtask

    task automatic test_alu();
        ex_isa_pkg::ex_op_e  ops[14];
        ex_pipe_pkg::id_ex_t it;
        ex_isa_pkg::word_t   a;
        ex_isa_pkg::word_t   b;
        ops = '{ex_isa_pkg::op_add, ex_isa_pkg::op_sub, ex_isa_pkg::op_sll,
                ex_isa_pkg::op_slt, ex_isa_pkg::op_sltu, ex_isa_pkg::op_xor,
                ex_isa_pkg::op_srl, ex_isa_pkg::op_sra, ex_isa_pkg::op_or,
                ex_isa_pkg::op_and, ex_isa_pkg::op_lui, ex_isa_pkg::op_auipc,
                ex_isa_pkg::op_load, ex_isa_pkg::op_store};
        foreach (ops[i]) begin
            for (int imm_form = 0; imm_form < 2; imm_form++) begin
                a  = rand_word(64);
                b  = rand_word(64);
                it = make_item(ops[i], imm_form[0], 5'd1, 5'd2, a, b, rand_imm());
                run_single($sformatf("alu %s imm=%0d", ops[i].name(), imm_form), it, a, b);
            end
        end
    endtask

    task automatic bypass_case(input string test, input ex_isa_pkg::reg_idx_t rs1,
                               input ex_isa_pkg::reg_idx_t rs2,
                               input ex_pipe_pkg::bypass_t m, input ex_pipe_pkg::bypass_t w,
                               input ex_isa_pkg::word_t ra, input ex_isa_pkg::word_t rb,
                               input ex_isa_pkg::word_t exp_a, input ex_isa_pkg::word_t exp_b);
        ex_pipe_pkg::id_ex_t it;
        it      = make_item(ex_isa_pkg::op_add, 1'b0, rs1, rs2, ra, rb, '0);
        mem_fwd = m;
        wb_fwd  = w;
        run_single(test, it, exp_a, exp_b);
        mem_fwd = '0;
        wb_fwd  = '0;
    endtask

    task automatic test_bypass();
        ex_isa_pkg::word_t ra;
        ex_isa_pkg::word_t rb;
        ex_isa_pkg::word_t dm;
        ex_isa_pkg::word_t dw;
        ra = rand_word(64);
        rb = rand_word(64);
        dm = rand_word(64);
        dw = rand_word(64);
        bypass_case("bypass mem over wb", 5'd5, 5'd6, '{1'b1, 5'd5, dm}, '{1'b1, 5'd5, dw},
                    ra, rb, dm, rb);
        bypass_case("bypass wb over reg", 5'd5, 5'd6, '{1'b1, 5'd7, dm}, '{1'b1, 5'd6, dw},
                    ra, rb, ra, dw);
        bypass_case("bypass wen low", 5'd5, 5'd6, '{1'b0, 5'd5, dm}, '{1'b0, 5'd6, dw},
                    ra, rb, ra, rb);
        bypass_case("bypass x0", 5'd0, 5'd0, '{1'b1, 5'd0, dm}, '{1'b1, 5'd0, dw},
                    ra, rb, ra, rb);
    endtask

    task automatic test_branch();
        ex_isa_pkg::ex_op_e  ops[6];
        ex_pipe_pkg::id_ex_t it;
        ex_isa_pkg::word_t   x;
        ex_isa_pkg::word_t   neg;
        ex_isa_pkg::word_t   pos;
        ex_isa_pkg::word_t   a;
        ex_isa_pkg::word_t   b;
        ops = '{ex_isa_pkg::op_beq, ex_isa_pkg::op_bne, ex_isa_pkg::op_blt,
                ex_isa_pkg::op_bge, ex_isa_pkg::op_bltu, ex_isa_pkg::op_bgeu};
        foreach (ops[i]) begin
            x   = rand_word(64);
            neg = rand_word(63) | {1'b1, {(ex_isa_pkg::xlen-1){1'b0}}};
            pos = rand_word(63);
            // equal, negative vs positive, positive vs negative
            for (int k = 0; k < 3; k++) begin
                a  = (k == 0) ? x : ((k == 1) ? neg : pos);
                b  = (k == 0) ? x : ((k == 1) ? pos : neg);
                it = make_item(ops[i], 1'b0, 5'd3, 5'd4, a, b,
                               rand_imm() & ~ex_isa_pkg::word_t'(1));
                run_single($sformatf("branch %s case %0d", ops[i].name(), k), it, a, b);
            end
        end
        it = make_item(ex_isa_pkg::op_jal, 1'b0, 5'd0, 5'd0, '0, '0,
                       rand_imm() & ~ex_isa_pkg::word_t'(1));
        run_single("jal", it, '0, '0);
        // odd base so the target needs bit 0 cleared
        a  = rand_word(64) | ex_isa_pkg::word_t'(1);
        it = make_item(ex_isa_pkg::op_jalr, 1'b1, 5'd3, 5'd0, a, '0,
                       rand_imm() & ~ex_isa_pkg::word_t'(1));
        run_single("jalr", it, a, '0);
    endtask

    task automatic mul_case(input string test, input ex_isa_pkg::word_t a,
                            input ex_isa_pkg::word_t b);
        ex_pipe_pkg::id_ex_t it;
        int                  edges;
        it    = make_item(ex_isa_pkg::op_mul, 1'b0, 5'd8, 5'd9, a, b, '0);
        accept(it);
        edges = 0;
        @(negedge clk);
        while (!out_valid) begin
            check_bit(test, 1'b0, in_ready);
            @(negedge clk);
            edges++;
        end
        check_latency(test, mul_steps + 1, edges);
        check_ex_mem(test, expect_out(it, a, b), out_item);
        check_bit(test, 1'b1, in_ready);
        @(posedge clk);
        #drive_dly;
    endtask

    task automatic test_mul();
        ex_pipe_pkg::id_ex_t it;
        ex_isa_pkg::word_t   a;
        ex_isa_pkg::word_t   msb;
        msb = {1'b1, {(ex_isa_pkg::xlen-1){1'b0}}};
        mul_case("mul random", rand_word(64), rand_word(64));
        a  = rand_word(64);
        it = make_item(ex_isa_pkg::op_add, 1'b1, 5'd1, 5'd0, a, '0, rand_imm());
        run_single("add after mul", it, a, '0);
        mul_case("mul high bits", rand_word(64) | msb, rand_word(64) | msb);
        a  = rand_word(64);
        it = make_item(ex_isa_pkg::op_sub, 1'b0, 5'd1, 5'd2, a, a, '0);
        run_single("sub after mul", it, a, a);
    endtask

    task automatic test_backpressure();
        ex_pipe_pkg::id_ex_t it;
        ex_isa_pkg::word_t   a;
        a  = rand_word(64);
        it = make_item(ex_isa_pkg::op_beq, 1'b0, 5'd3, 5'd4, a, a,
                       rand_imm() & ~ex_isa_pkg::word_t'(1));
        accept(it);
        out_ready = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_bit("backpressure out_valid", 1'b1, out_valid);
            check_ex_mem("backpressure hold", expect_out(it, a, a), out_item);
            check_bit("backpressure redirect", 1'b0, redirect.valid);
        end
        @(posedge clk);
        #drive_dly;
        out_ready = 1'b1;
        @(negedge clk);
        check_ex_mem("backpressure release", expect_out(it, a, a), out_item);
        check_redirect("backpressure release", ref_redirect(it, a, a), redirect);
        @(posedge clk);
        #drive_dly;
    endtask

    // a held item and a multiply in flight are both dropped by flush
    task automatic test_flush();
        ex_pipe_pkg::id_ex_t it;
        ex_isa_pkg::word_t   a;
        a  = rand_word(64);
        it = make_item(ex_isa_pkg::op_add, 1'b1, 5'd1, 5'd0, a, '0, rand_imm());
        accept(it);
        // without the flush the item would stay valid under back-pressure
        out_ready = 1'b0;
        flush     = 1'b1;
        @(posedge clk);
        #drive_dly;
        flush     = 1'b0;
        out_ready = 1'b1;
        @(negedge clk);
        check_bit("flush out_valid", 1'b0, out_valid);
        @(posedge clk);
        #drive_dly;
        it = make_item(ex_isa_pkg::op_mul, 1'b0, 5'd8, 5'd9, a, rand_word(64), '0);
        accept(it);
        repeat (3) @(posedge clk);
        #drive_dly;
        flush = 1'b1;
        @(posedge clk);
        #drive_dly;
        flush = 1'b0;
        @(negedge clk);
        check_bit("flush in_ready", 1'b1, in_ready);
        @(posedge clk);
        #drive_dly;
        it = make_item(ex_isa_pkg::op_add, 1'b1, 5'd1, 5'd0, a, '0, rand_imm());
        run_single("add after flush", it, a, '0);
    endtask

    initial begin
        cycles    = 0;
        lfsr_q    = 32'd89726;
        next_pc   = 64'h8000_0000;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_item   = '0;
        out_ready = 1'b1;
        mem_fwd   = '0;
        wb_fwd    = '0;
        flush     = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #drive_dly;
        rst_n = 1'b1;
        test_reset();
        test_alu();
        test_bypass();
        test_branch();
        test_mul();
        test_backpressure();
        test_flush();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
source/ex_isa_pkg.sv
source/ex_pipe_pkg.sv
source/ex_stage_reg.sv
source/ex_bypass.sv
source/ex_alu.sv
source/ex_branch.sv
source/ex_multiplier.sv
source/ex_stage.sv
verif/ex_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
LOG       ?= sim.log
MUL_BITS  ?= 2
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build and run, then scan the log for a failure
sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Gmul_bits_per_cycle=$(MUL_BITS) -Mdir $(OBJ_DIR) -f compile.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
		if grep -q "Testbench failed" $(LOG); then exit 1; fi; \
		exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
